/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal --timescale 1ns/1ps
TOP      := tb_lsu_top
RTL_TOP  := lsu_top
FILELIST := lsu_top.f
BUILD    := obj_dir
LOG      := sim.log
PASS     := TEST OK

SOURCES  := $(wildcard source/*.sv source/*.svh sim/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS)" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

/* lsu_top.f */
+incdir+source
source/lsu_pkg.sv
source/lsu_ctrl_decoder.sv
source/lsu_tlb.sv
source/lsu_data_ram.sv
source/lsu_store_buffer.sv
source/lsu_pipe.sv
source/lsu_top.sv
sim/tb_lsu_top.sv

/* sim/lsu_input.txt */
# T vpn ppn : TLB fill
# I inst rs1 rs2 rd fault data : issue, then expected completion (fault 0 none 1 miss 2 misalign 3 illegal)
T 000010 3
T 000011 5
# Word store and back-to-back load
I 0020A023 00001000 11223344 01 0 00000000
I 0000A183 00001000 00000000 02 0 11223344
# Byte and half extension at every offset
I 0020A023 00001004 80F17F01 03 0 00000000
I 00008183 00001004 00000000 04 0 00000001
I 00108183 00001004 00000000 05 0 0000007F
I 00208183 00001004 00000000 06 0 FFFFFFF1
I 00308183 00001004 00000000 07 0 FFFFFF80
I 0000C183 00001004 00000000 08 0 00000001
I 0010C183 00001004 00000000 09 0 0000007F
I 0020C183 00001004 00000000 0A 0 000000F1
I 0030C183 00001004 00000000 0B 0 00000080
I 00009183 00001004 00000000 0C 0 00007F01
I 00209183 00001004 00000000 0D 0 FFFF80F1
I 0000D183 00001004 00000000 0E 0 00007F01
I 0020D183 00001004 00000000 0F 0 000080F1
# Page miss, then fill and retry
I 0020A023 00001200 CAFEF00D 10 1 00000000
I 0000A183 00001200 00000000 11 1 00000000
T 000012 7
I 0020A023 00001200 CAFEF00D 12 0 00000000
I 0000A183 00001200 00000000 13 0 CAFEF00D
# Misaligned, illegal, and a faulting store that leaves memory alone
I 00109183 00001000 00000000 14 2 00000000
I 0020A183 00001000 00000000 15 2 00000000
I 002081B3 00001000 00000000 16 3 00000000
I 0020A123 00001000 DEADBEEF 17 2 00000000
I 0000A183 00001000 00000000 18 0 11223344
# Store burst deeper than the store buffer, with byte merges
I 0020A023 00001100 00000000 19 0 00000000
I 0020A223 00001100 55667788 1A 0 00000000
I 002080A3 00001100 123456AA 1B 0 00000000
I 00209123 00001100 FFFFBBCC 1C 0 00000000
I 0020A423 00001100 0BADCAFE 1D 0 00000000
I 00208223 00001100 0000005A 1E 0 00000000
I 0000A183 00001100 00000000 1F 0 BBCCAA00
I 0040A183 00001100 00000000 00 0 5566775A
I 0080A183 00001100 00000000 01 0 0BADCAFE
I 00108183 00001100 00000000 02 0 FFFFFFAA

/* sim/tb_lsu_top.sv */
`include "lsu_defines.svh"

module tb_lsu_top
  import lsu_pkg::*;
();

  typedef struct packed {
    logic        is_fill;
    logic [31:0] inst;  // vpn for a fill
    logic [31:0] rs1;   // ppn for a fill
    logic [31:0] rs2;
    logic [4:0]  rd;
    logic [1:0]  fault;
    logic [31:0] data;
  } stim_t;

  typedef struct packed {
    logic [4:0]  rd;
    logic [1:0]  fault;
    logic [31:0] data;
  } exp_t;

  logic                                i_clk;
  logic                                i_reset_n;
  logic                                i_issue_valid;
  logic [31:0]                         i_issue_inst;
  logic [`LSU_VADDR_W-1:0]             i_issue_rs1_data;
  logic [31:0]                         i_issue_rs2_data;
  logic [4:0]                          i_issue_rd;
  logic                                o_issue_ready;
  logic                                i_tlb_wr_valid;
  logic [`LSU_VADDR_W-`LSU_PAGE_W-1:0] i_tlb_wr_vpn;
  logic [`LSU_PADDR_W-`LSU_PAGE_W-1:0] i_tlb_wr_ppn;
  logic                                o_wb_valid;
  logic [4:0]                          o_wb_rd;
  logic [31:0]                         o_wb_data;
  lsu_fault_t                          o_wb_fault;
  logic                                i_wb_ready;

  stim_t stim_q[$];
  exp_t  exp_q[$];
  bit    load_done = 1'b0;
  int    checks = 0;
  int    value_errors = 0;
  int    other_errors = 0;

  lsu_top UUT (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_issue_valid    (i_issue_valid),
    .i_issue_inst     (i_issue_inst),
    .i_issue_rs1_data (i_issue_rs1_data),
    .i_issue_rs2_data (i_issue_rs2_data),
    .i_issue_rd       (i_issue_rd),
    .o_issue_ready    (o_issue_ready),
    .i_tlb_wr_valid   (i_tlb_wr_valid),
    .i_tlb_wr_vpn     (i_tlb_wr_vpn),
    .i_tlb_wr_ppn     (i_tlb_wr_ppn),
    .o_wb_valid       (o_wb_valid),
    .o_wb_rd          (o_wb_rd),
    .o_wb_data        (o_wb_data),
    .o_wb_fault       (o_wb_fault),
    .i_wb_ready       (i_wb_ready)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      value_errors++;
      $display("[FAIL] %s got 0x%h expected 0x%h at %0t", name, got, expected, $time);
    end
  endtask

  task automatic load_stimulus(output bit ok);
    integer fd;
    integer n;
    string  line;
    string  body;
    stim_t  s;
    logic [31:0] f0, f1, f2, f3, f4, f5;
    ok = 1'b0;
    fd = $fopen("sim/lsu_input.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while ($fgets(line, fd) != 0) begin
        if (line.len() >= 2 && line.getc(0) != "#") begin
          body = line.substr(2, line.len() - 1);
          s = '0;
          if (line.getc(0) == "T") begin
            n = $sscanf(body, "%h %h", f0, f1);
            s.is_fill = 1'b1;
            s.inst    = f0;
            s.rs1     = f1;
            if (n == 2) stim_q.push_back(s);
            else n = -1;
          end else if (line.getc(0) == "I") begin
            n = $sscanf(body, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
            s.inst  = f0;
            s.rs1   = f1;
            s.rs2   = f2;
            s.rd    = f3[4:0];
            s.fault = f4[1:0];
            s.data  = f5;
            if (n == 6) stim_q.push_back(s);
            else n = -1;
          end else begin
            n = -1;
          end
          if (n < 0) begin
            other_errors++;
            $display("Skipped a malformed line in the stimulus file: %s", line);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge i_clk);
      #1;
    end
  endtask

  // Pipe must be empty so that in-flight lookups see the old TLB state
  task automatic fill_tlb(input stim_t s);
    i_issue_valid = 1'b0;
    wait_drained();
    i_tlb_wr_valid = 1'b1;
    i_tlb_wr_vpn   = s.inst[`LSU_VADDR_W-`LSU_PAGE_W-1:0];
    i_tlb_wr_ppn   = s.rs1[`LSU_PADDR_W-`LSU_PAGE_W-1:0];
    @(posedge i_clk);
    #1;
    i_tlb_wr_valid = 1'b0;
  endtask

  task automatic issue_op(input stim_t s);
    exp_t e;
    bit   accepted;
    e.rd    = s.rd;
    e.fault = s.fault;
    e.data  = s.data;
    exp_q.push_back(e);
    i_issue_valid    = 1'b1;
    i_issue_inst     = s.inst;
    i_issue_rs1_data = s.rs1;
    i_issue_rs2_data = s.rs2;
    i_issue_rd       = s.rd;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge i_clk);
      accepted = o_issue_ready; // Handshake at the next rising edge
      @(posedge i_clk);
      #1;
    end
  endtask

  task automatic print_summary();
    $display("Checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
  endtask

  task automatic finish_run();
    print_summary();
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  // Completion monitor sampled mid-cycle
  initial begin : monitor
    exp_t e;
    forever begin
      @(negedge i_clk);
      if (i_reset_n && o_wb_valid && i_wb_ready) begin
        if (exp_q.size() == 0) begin
          other_errors++;
          $display("Completion for rd %h arrived with no operation outstanding", o_wb_rd);
        end else begin
          e = exp_q.pop_front();
          check_value("o_wb_rd", 32'(o_wb_rd), 32'(e.rd));
          check_value("o_wb_fault", 32'(o_wb_fault), 32'(e.fault));
          check_value("o_wb_data", o_wb_data, e.data);
        end
      end
    end
  end

  initial begin : wb_ready_gen
    integer seed;
    seed = 32'hb0511f9d;
    wait (i_reset_n);
    forever begin
      @(posedge i_clk);
      #1;
      i_wb_ready = ($random(seed) & 3) != 0; // Ready about three cycles in four
    end
  end

  initial begin : watchdog
    int unsigned limit;
    wait (load_done);
    limit = stim_q.size() * 20 + 200;
    repeat (limit) @(posedge i_clk);
    other_errors++;
    $display("Timeout after %0d cycles with %0d completions outstanding", limit, exp_q.size());
    print_summary();
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main_flow
    bit ok;
    i_reset_n        = 1'b0;
    i_issue_valid    = 1'b0;
    i_issue_inst     = '0;
    i_issue_rs1_data = '0;
    i_issue_rs2_data = '0;
    i_issue_rd       = '0;
    i_tlb_wr_valid   = 1'b0;
    i_tlb_wr_vpn     = '0;
    i_tlb_wr_ppn     = '0;
    i_wb_ready       = 1'b1;
    load_stimulus(ok);
    if (!ok) begin
      other_errors++;
      $display("Cannot open the stimulus file sim/lsu_input.txt");
      print_summary();
      $display("TEST FAILED");
      $finish;
    end else begin
      load_done = 1'b1;
      repeat (16) @(posedge i_clk);
      #1;
      i_reset_n = 1'b1;
      @(negedge i_clk);
      check_value("o_wb_valid", 32'(o_wb_valid), 32'h0);
      check_value("o_issue_ready", 32'(o_issue_ready), 32'h1);
      @(posedge i_clk);
      #1;
      foreach (stim_q[i]) begin
        if (stim_q[i].is_fill) fill_tlb(stim_q[i]);
        else issue_op(stim_q[i]);
      end
      i_issue_valid = 1'b0;
      wait_drained();
      repeat (8) @(posedge i_clk); // Catch any extra completion
      finish_run();
    end
  end

endmodule

/* source/lsu_ctrl_decoder.sv */
`include "lsu_defines.svh"

module lsu_ctrl_decoder
  import lsu_pkg::*;
(
  input  logic [31:0]             i_inst,
  output lsu_op_t                 o_op,
  output logic [`LSU_VADDR_W-1:0] o_imm
);

  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  logic [2:0] w_funct3;

  assign w_funct3 = i_inst[14:12];

  always_comb begin
    o_op  = OP_ILLEGAL;
    // I-type unless a store
    o_imm = {{(`LSU_VADDR_W-12){i_inst[31]}}, i_inst[31:20]};
    case (i_inst[6:0])
      OPC_LOAD: begin
        case (w_funct3)
          3'b000:  o_op = OP_LB;
          3'b001:  o_op = OP_LH;
          3'b010:  o_op = OP_LW;
          3'b100:  o_op = OP_LBU;
          3'b101:  o_op = OP_LHU;
          default: o_op = OP_ILLEGAL;
        endcase
      end
      OPC_STORE: begin
        o_imm = {{(`LSU_VADDR_W-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]}; // S-type
        case (w_funct3)
          3'b000:  o_op = OP_SB;
          3'b001:  o_op = OP_SH;
          3'b010:  o_op = OP_SW;
          default: o_op = OP_ILLEGAL;
        endcase
      end
      default: o_op = OP_ILLEGAL;
    endcase
  end

endmodule

/* source/lsu_data_ram.sv */
`include "lsu_defines.svh"

module lsu_data_ram (
  input  logic                     i_clk,
  input  logic [`LSU_PADDR_W-3:0]  i_rd_addr,
  input  logic                     i_wr_en,
  input  logic [`LSU_PADDR_W-3:0]  i_wr_addr,
  input  logic [3:0]               i_wr_mask,
  input  logic [31:0]              i_wr_data,
  output logic [31:0]              o_rd_data
);

  logic [31:0] r_mem [`LSU_RAM_WORDS];

  logic w_same_addr;

  assign w_same_addr = i_wr_en && (i_wr_addr == i_rd_addr);

  // Byte-masked write
  always_ff @(posedge i_clk) begin
    for (int b = 0; b < 4; b++) begin
      if (i_wr_en && i_wr_mask[b]) begin
        r_mem[i_wr_addr][8*b +: 8] <= i_wr_data[8*b +: 8];
      end
    end
  end

  // Registered read, new bytes win on a collision
  always_ff @(posedge i_clk) begin
    for (int b = 0; b < 4; b++) begin
      if (w_same_addr && i_wr_mask[b]) begin
        o_rd_data[8*b +: 8] <= i_wr_data[8*b +: 8];
      end else begin
        o_rd_data[8*b +: 8] <= r_mem[i_rd_addr][8*b +: 8];
      end
    end
  end

endmodule

/* source/lsu_defines.svh */
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Address widths
`define LSU_VADDR_W 32
`define LSU_PAGE_W 8 // 256-byte pages
`define LSU_PADDR_W 12 // Covers the 4 KB RAM

// Data RAM depth in 32-bit words
`define LSU_RAM_WORDS 1024

// Direct-mapped TLB size
`define LSU_TLB_ENTRIES 8

// Pending stores
`define LSU_SB_DEPTH 4

`endif

/* source/lsu_pipe.sv */
`include "lsu_defines.svh"

module lsu_pipe
  import lsu_pkg::*;
(
  input  logic                                i_clk,
  input  logic                                i_reset_n,
  input  logic                                i_issue_valid,
  input  logic [31:0]                         i_issue_inst,
  input  logic [`LSU_VADDR_W-1:0]             i_issue_rs1_data,
  input  logic [31:0]                         i_issue_rs2_data,
  input  logic [4:0]                          i_issue_rd,
  output logic                                o_issue_ready,
  output logic                                o_wb_valid,
  output logic [4:0]                          o_wb_rd,
  output logic [31:0]                         o_wb_data,
  output lsu_fault_t                          o_wb_fault,
  input  logic                                i_wb_ready,
  output logic [`LSU_VADDR_W-`LSU_PAGE_W-1:0] o_tlb_vpn,
  input  logic                                i_tlb_hit,
  input  logic [`LSU_PADDR_W-`LSU_PAGE_W-1:0] i_tlb_ppn,
  output logic [`LSU_PADDR_W-3:0]             o_ram_rd_addr,
  input  logic [31:0]                         i_ram_rd_data,
  output logic                                o_sb_push,
  output logic [`LSU_PADDR_W-3:0]             o_sb_addr,
  output logic [3:0]                          o_sb_mask,
  output logic [31:0]                         o_sb_data,
  input  logic                                i_sb_full,
  output logic [`LSU_PADDR_W-3:0]             o_fwd_addr,
  input  logic [3:0]                          i_fwd_mask,
  input  logic [31:0]                         i_fwd_data
);

  logic                    r_ex0_valid, r_ex1_valid, r_ex2_valid;
  logic [31:0]             r_ex0_inst;
  logic [`LSU_VADDR_W-1:0] r_ex0_rs1, r_ex1_rs1;
  logic [31:0]             r_ex0_rs2, r_ex1_rs2, r_ex2_rs2;
  logic [4:0]              r_ex0_rd, r_ex1_rd, r_ex2_rd;
  lsu_op_t                 w_ex0_op, r_ex1_op, r_ex2_op;
  logic [`LSU_VADDR_W-1:0] w_ex0_imm, r_ex1_imm;

  logic [`LSU_VADDR_W-1:0] w_ex1_vaddr;
  logic [`LSU_PADDR_W-1:0] w_ex1_paddr, r_ex2_paddr;
  lsu_fault_t              w_ex1_fault, r_ex2_fault;
  logic                    w_ex1_misalign;

  logic        w_ex2_is_store, w_ex2_push_req;
  logic [31:0] w_ex2_merged, w_ex2_shifted, w_ex2_ld_data;
  logic        w_stall;

  // Every stage freezes together
  assign w_stall       = (o_wb_valid && !i_wb_ready) || (w_ex2_push_req && i_sb_full);
  assign o_issue_ready = !w_stall;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex0_valid <= 1'b0;
      r_ex1_valid <= 1'b0;
      r_ex2_valid <= 1'b0;
      o_wb_valid  <= 1'b0;
    end else if (!w_stall) begin
      r_ex0_valid <= i_issue_valid;
      r_ex1_valid <= r_ex0_valid;
      r_ex2_valid <= r_ex1_valid;
      o_wb_valid  <= r_ex2_valid;
    end
  end

  // EX0 decode
  lsu_ctrl_decoder u_decoder (
    .i_inst (r_ex0_inst),
    .o_op   (w_ex0_op),
    .o_imm  (w_ex0_imm)
  );

  // EX1 address, translation and fault priority
  assign w_ex1_vaddr = r_ex1_rs1 + r_ex1_imm;
  assign o_tlb_vpn   = w_ex1_vaddr[`LSU_VADDR_W-1:`LSU_PAGE_W];
  assign w_ex1_paddr = {i_tlb_ppn, w_ex1_vaddr[`LSU_PAGE_W-1:0]};

  always_comb begin
    case (r_ex1_op)
      OP_LH, OP_LHU, OP_SH: w_ex1_misalign = w_ex1_vaddr[0];
      OP_LW, OP_SW:         w_ex1_misalign = |w_ex1_vaddr[1:0];
      default:              w_ex1_misalign = 1'b0;
    endcase
    if (r_ex1_op == OP_ILLEGAL)  w_ex1_fault = FLT_ILLEGAL;
    else if (w_ex1_misalign)     w_ex1_fault = FLT_MISALIGN;
    else if (!i_tlb_hit)         w_ex1_fault = FLT_PAGE_MISS;
    else                         w_ex1_fault = FLT_NONE;
  end

  // While frozen, keep re-reading the EX2 word so the RAM output stays with it
  assign o_ram_rd_addr = w_stall ? r_ex2_paddr[`LSU_PADDR_W-1:2]
                                 : w_ex1_paddr[`LSU_PADDR_W-1:2];

  // EX2 load path
  assign o_fwd_addr = r_ex2_paddr[`LSU_PADDR_W-1:2];

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      w_ex2_merged[8*b +: 8] = i_fwd_mask[b] ? i_fwd_data[8*b +: 8] : i_ram_rd_data[8*b +: 8];
    end
    w_ex2_shifted = w_ex2_merged >> {r_ex2_paddr[1:0], 3'b000};
    case (r_ex2_op)
      OP_LB:   w_ex2_ld_data = {{24{w_ex2_shifted[7]}}, w_ex2_shifted[7:0]};
      OP_LBU:  w_ex2_ld_data = {24'h0, w_ex2_shifted[7:0]};
      OP_LH:   w_ex2_ld_data = {{16{w_ex2_shifted[15]}}, w_ex2_shifted[15:0]};
      OP_LHU:  w_ex2_ld_data = {16'h0, w_ex2_shifted[15:0]};
      OP_LW:   w_ex2_ld_data = w_ex2_shifted;
      default: w_ex2_ld_data = 32'h0; // Stores and illegal
    endcase
  end

  // EX2 store path
  assign w_ex2_is_store = (r_ex2_op == OP_SB) || (r_ex2_op == OP_SH) || (r_ex2_op == OP_SW);
  assign w_ex2_push_req = r_ex2_valid && w_ex2_is_store && (r_ex2_fault == FLT_NONE);
  assign o_sb_push      = w_ex2_push_req && !w_stall;
  assign o_sb_addr      = r_ex2_paddr[`LSU_PADDR_W-1:2];

  always_comb begin
    case (r_ex2_op)
      OP_SB: begin
        o_sb_mask = 4'b0001 << r_ex2_paddr[1:0];
        o_sb_data = {4{r_ex2_rs2[7:0]}};
      end
      OP_SH: begin
        o_sb_mask = 4'b0011 << r_ex2_paddr[1:0];
        o_sb_data = {2{r_ex2_rs2[15:0]}};
      end
      default: begin
        o_sb_mask = 4'b1111;
        o_sb_data = r_ex2_rs2;
      end
    endcase
  end

  // Stage payloads
  always_ff @(posedge i_clk) begin
    if (!w_stall) begin
      r_ex0_inst  <= i_issue_inst;
      r_ex0_rs1   <= i_issue_rs1_data;
      r_ex0_rs2   <= i_issue_rs2_data;
      r_ex0_rd    <= i_issue_rd;
      r_ex1_op    <= w_ex0_op;
      r_ex1_imm   <= w_ex0_imm;
      r_ex1_rs1   <= r_ex0_rs1;
      r_ex1_rs2   <= r_ex0_rs2;
      r_ex1_rd    <= r_ex0_rd;
      r_ex2_op    <= r_ex1_op;
      r_ex2_paddr <= w_ex1_paddr;
      r_ex2_fault <= w_ex1_fault;
      r_ex2_rs2   <= r_ex1_rs2;
      r_ex2_rd    <= r_ex1_rd;
      o_wb_rd     <= r_ex2_rd;
      o_wb_fault  <= r_ex2_fault;
      o_wb_data   <= (r_ex2_fault == FLT_NONE) ? w_ex2_ld_data : 32'h0;
    end
  end

  a_wb_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_wb_valid && !i_wb_ready) |=>
      (o_wb_valid && $stable(o_wb_rd) && $stable(o_wb_data) && $stable(o_wb_fault)));

endmodule

/* source/lsu_pkg.sv */
`include "lsu_defines.svh"

package lsu_pkg;

  // Memory operations, decoded in EX0
  typedef enum logic [3:0] {
    OP_LB,
    OP_LH,
    OP_LW,
    OP_LBU,
    OP_LHU,
    OP_SB,
    OP_SH,
    OP_SW,
    OP_ILLEGAL
  } lsu_op_t;

  // Completion fault codes
  typedef enum logic [1:0] {
    FLT_NONE,
    FLT_PAGE_MISS,
    FLT_MISALIGN,
    FLT_ILLEGAL
  } lsu_fault_t;

  // One pending store, word addressed
  typedef struct packed {
    logic [`LSU_PADDR_W-3:0] addr;
    logic [3:0]              mask; // Byte enables
    logic [31:0]             data;
  } lsu_sb_entry_t;

endpackage

/* source/lsu_store_buffer.sv */
`include "lsu_defines.svh"

module lsu_store_buffer
  import lsu_pkg::*;
#(
  parameter int DEPTH = 4
)
(
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic                    i_push,
  input  logic [`LSU_PADDR_W-3:0] i_push_addr,
  input  logic [3:0]              i_push_mask,
  input  logic [31:0]             i_push_data,
  input  logic [`LSU_PADDR_W-3:0] i_fwd_addr,
  output logic                    o_full,
  output logic [3:0]              o_fwd_mask,
  output logic [31:0]             o_fwd_data,
  output logic                    o_ram_wr_en,
  output logic [`LSU_PADDR_W-3:0] o_ram_wr_addr,
  output logic [3:0]              o_ram_wr_mask,
  output logic [31:0]             o_ram_wr_data
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  lsu_sb_entry_t    r_entries [DEPTH];
  logic [PTR_W-1:0] r_head;
  logic [PTR_W-1:0] r_tail;
  logic [CNT_W-1:0] r_count;
  logic             w_pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign o_full = (r_count == CNT_W'(DEPTH));
  assign w_pop  = (r_count != '0); // Drain every cycle while non-empty

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head  <= '0;
      r_tail  <= '0;
      r_count <= '0;
    end else begin
      if (i_push) r_tail <= ptr_inc(r_tail);
      if (w_pop) r_head <= ptr_inc(r_head);
      r_count <= r_count + CNT_W'(i_push) - CNT_W'(w_pop);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      r_entries[r_tail] <= '{addr: i_push_addr, mask: i_push_mask, data: i_push_data};
    end
  end

  assign o_ram_wr_en   = w_pop;
  assign o_ram_wr_addr = r_entries[r_head].addr;
  assign o_ram_wr_mask = r_entries[r_head].mask;
  assign o_ram_wr_data = r_entries[r_head].data;

  // Oldest to youngest, so later matches overwrite earlier bytes
  always_comb begin
    logic [PTR_W:0]   pos;
    logic [PTR_W-1:0] slot;
    o_fwd_mask = '0;
    o_fwd_data = '0;
    for (int i = 0; i < DEPTH; i++) begin
      pos = {1'b0, r_head} + (PTR_W+1)'(i);
      if (pos >= (PTR_W+1)'(DEPTH)) pos = pos - (PTR_W+1)'(DEPTH);
      slot = pos[PTR_W-1:0];
      if ((CNT_W'(i) < r_count) && (r_entries[slot].addr == i_fwd_addr)) begin
        for (int b = 0; b < 4; b++) begin
          if (r_entries[slot].mask[b]) begin
            o_fwd_mask[b]        = 1'b1;
            o_fwd_data[8*b +: 8] = r_entries[slot].data[8*b +: 8];
          end
        end
      end
    end
  end

  // The pipe must hold a store in EX2 while the buffer is full
  a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_push && o_full));

endmodule

/* source/lsu_tlb.sv */
`include "lsu_defines.svh"

module lsu_tlb (
  input  logic                                i_clk,
  input  logic                                i_reset_n,
  input  logic                                i_wr_valid,
  input  logic [`LSU_VADDR_W-`LSU_PAGE_W-1:0] i_wr_vpn,
  input  logic [`LSU_PADDR_W-`LSU_PAGE_W-1:0] i_wr_ppn,
  input  logic [`LSU_VADDR_W-`LSU_PAGE_W-1:0] i_lookup_vpn,
  output logic                                o_hit,
  output logic [`LSU_PADDR_W-`LSU_PAGE_W-1:0] o_ppn
);

  localparam int VPN_W = `LSU_VADDR_W - `LSU_PAGE_W;
  localparam int PPN_W = `LSU_PADDR_W - `LSU_PAGE_W;
  localparam int IDX_W = $clog2(`LSU_TLB_ENTRIES);
  localparam int TAG_W = VPN_W - IDX_W;

  logic [`LSU_TLB_ENTRIES-1:0] r_valid;
  logic [TAG_W-1:0]            r_tag [`LSU_TLB_ENTRIES];
  logic [PPN_W-1:0]            r_ppn [`LSU_TLB_ENTRIES];

  logic [IDX_W-1:0] w_wr_idx;
  logic [IDX_W-1:0] w_lk_idx;

  assign w_wr_idx = i_wr_vpn[IDX_W-1:0];
  assign w_lk_idx = i_lookup_vpn[IDX_W-1:0];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else if (i_wr_valid) begin
      r_valid[w_wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_wr_valid) begin
      r_tag[w_wr_idx] <= i_wr_vpn[VPN_W-1:IDX_W]; // Fill overwrites
      r_ppn[w_wr_idx] <= i_wr_ppn;
    end
  end

  // Same-cycle lookup
  assign o_hit = r_valid[w_lk_idx] && (r_tag[w_lk_idx] == i_lookup_vpn[VPN_W-1:IDX_W]);
  assign o_ppn = r_ppn[w_lk_idx];

endmodule

/* source/lsu_top.sv */
`include "lsu_defines.svh"

module lsu_top
  import lsu_pkg::*;
(
  input  logic                                i_clk,
  input  logic                                i_reset_n,
  input  logic                                i_issue_valid,
  input  logic [31:0]                         i_issue_inst,
  input  logic [`LSU_VADDR_W-1:0]             i_issue_rs1_data,
  input  logic [31:0]                         i_issue_rs2_data,
  input  logic [4:0]                          i_issue_rd,
  output logic                                o_issue_ready,
  input  logic                                i_tlb_wr_valid,
  input  logic [`LSU_VADDR_W-`LSU_PAGE_W-1:0] i_tlb_wr_vpn,
  input  logic [`LSU_PADDR_W-`LSU_PAGE_W-1:0] i_tlb_wr_ppn,
  output logic                                o_wb_valid,
  output logic [4:0]                          o_wb_rd,
  output logic [31:0]                         o_wb_data,
  output lsu_fault_t                          o_wb_fault,
  input  logic                                i_wb_ready
);

  logic [`LSU_VADDR_W-`LSU_PAGE_W-1:0] w_tlb_vpn;
  logic                                w_tlb_hit;
  logic [`LSU_PADDR_W-`LSU_PAGE_W-1:0] w_tlb_ppn;
  logic [`LSU_PADDR_W-3:0]             w_ram_rd_addr, w_ram_wr_addr;
  logic [31:0]                         w_ram_rd_data, w_ram_wr_data;
  logic                                w_ram_wr_en;
  logic [3:0]                          w_ram_wr_mask;
  logic                                w_sb_push, w_sb_full;
  logic [`LSU_PADDR_W-3:0]             w_sb_addr, w_fwd_addr;
  logic [3:0]                          w_sb_mask, w_fwd_mask;
  logic [31:0]                         w_sb_data, w_fwd_data;

  lsu_pipe u_pipe (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_issue_valid    (i_issue_valid),
    .i_issue_inst     (i_issue_inst),
    .i_issue_rs1_data (i_issue_rs1_data),
    .i_issue_rs2_data (i_issue_rs2_data),
    .i_issue_rd       (i_issue_rd),
    .o_issue_ready    (o_issue_ready),
    .o_wb_valid       (o_wb_valid),
    .o_wb_rd          (o_wb_rd),
    .o_wb_data        (o_wb_data),
    .o_wb_fault       (o_wb_fault),
    .i_wb_ready       (i_wb_ready),
    .o_tlb_vpn        (w_tlb_vpn),
    .i_tlb_hit        (w_tlb_hit),
    .i_tlb_ppn        (w_tlb_ppn),
    .o_ram_rd_addr    (w_ram_rd_addr),
    .i_ram_rd_data    (w_ram_rd_data),
    .o_sb_push        (w_sb_push),
    .o_sb_addr        (w_sb_addr),
    .o_sb_mask        (w_sb_mask),
    .o_sb_data        (w_sb_data),
    .i_sb_full        (w_sb_full),
    .o_fwd_addr       (w_fwd_addr),
    .i_fwd_mask       (w_fwd_mask),
    .i_fwd_data       (w_fwd_data)
  );

  lsu_tlb u_tlb (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_wr_valid   (i_tlb_wr_valid),
    .i_wr_vpn     (i_tlb_wr_vpn),
    .i_wr_ppn     (i_tlb_wr_ppn),
    .i_lookup_vpn (w_tlb_vpn),
    .o_hit        (w_tlb_hit),
    .o_ppn        (w_tlb_ppn)
  );

  lsu_data_ram u_ram (
    .i_clk     (i_clk),
    .i_rd_addr (w_ram_rd_addr),
    .i_wr_en   (w_ram_wr_en),
    .i_wr_addr (w_ram_wr_addr),
    .i_wr_mask (w_ram_wr_mask),
    .i_wr_data (w_ram_wr_data),
    .o_rd_data (w_ram_rd_data)
  );

  lsu_store_buffer #(
    .DEPTH (`LSU_SB_DEPTH)
  ) u_sb (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_push        (w_sb_push),
    .i_push_addr   (w_sb_addr),
    .i_push_mask   (w_sb_mask),
    .i_push_data   (w_sb_data),
    .i_fwd_addr    (w_fwd_addr),
    .o_full        (w_sb_full),
    .o_fwd_mask    (w_fwd_mask),
    .o_fwd_data    (w_fwd_data),
    .o_ram_wr_en   (w_ram_wr_en),
    .o_ram_wr_addr (w_ram_wr_addr),
    .o_ram_wr_mask (w_ram_wr_mask),
    .o_ram_wr_data (w_ram_wr_data)
  );

endmodule
